//--- flist.f
sys_bus_pkg.sv
analog_pkg.sv
sys_bus_decoder.sv
housekeeping_regs.sv
adc_frontend.sv
dac_backend.sv
rp_top.sv
tb_rp_top.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --timing
TOP       = tb_rp_top
FLIST     = flist.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = ALL CHECKS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_rp_top.sv
`timescale 1ns/10ps

module tb_rp_top
  import sys_bus_pkg::*;
  import analog_pkg::*;
();

  localparam int   TIMEOUT    = 20;     // Cycles per wait
  localparam int   DAC_CYCLES = 8;
  localparam led_t LED_VAL    = 8'h5A;
  localparam exp_t P_DIR_VAL  = 8'hF0;
  localparam exp_t N_DIR_VAL  = 8'h0F;
  localparam exp_t P_OUT_VAL  = 8'hA5;
  localparam exp_t N_OUT_VAL  = 8'h3C;

  // One bus access with its expected answer
  typedef struct packed {
    logic      wr;
    sys_addr_t addr;
    sys_data_t wdata;
    logic      chk;    // Compare read data
    sys_data_t rdata;
    logic      err;
  } access_t;

  logic        adc_clk;
  logic        reset_i;
  sys_req_t    sys_req_i;
  sys_rsp_t    sys_rsp_o;
  logic [15:0] adc_dat_a_i, adc_dat_b_i;
  dac_word_t   dac_dat_o;
  logic        dac_sel_o, dac_rst_o;
  led_t        led_o;
  exp_t        exp_p_dat_i, exp_n_dat_i;
  exp_t        exp_p_dat_o, exp_n_dat_o, exp_p_dir_o, exp_n_dir_o;

  int          seed;
  int          rnd;
  int          errors;
  int          checks;
  access_t     table_q[$];
  logic [15:0] pin_a, pin_b;        // Held on the ADC pins
  dac_code_t   code_a, code_b;
  exp_t        exp_p_drv, exp_n_drv;
  sys_data_t   rd;
  logic        er;

  rp_top i_rp_top (
    .adc_clk     (adc_clk),
    .reset_i     (reset_i),
    .sys_req_i   (sys_req_i),
    .sys_rsp_o   (sys_rsp_o),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .dac_dat_o   (dac_dat_o),
    .dac_sel_o   (dac_sel_o),
    .dac_rst_o   (dac_rst_o),
    .led_o       (led_o),
    .exp_p_dat_i (exp_p_dat_i),
    .exp_n_dat_i (exp_n_dat_i),
    .exp_p_dat_o (exp_p_dat_o),
    .exp_n_dat_o (exp_n_dat_o),
    .exp_p_dir_o (exp_p_dir_o),
    .exp_n_dir_o (exp_n_dir_o)
  );

  initial adc_clk = 1'b0;
  always #50 adc_clk = ~adc_clk;  // 100 ns period

  //////////////////////////////////////////////////
  // Expected values from the converter rules
  //////////////////////////////////////////////////

  // Sign kept and lower 13 inverted before sign extension
  function automatic sys_data_t adc_readback(logic [15:0] pin);
    logic [13:0] s;
    s = pin[15:2] ^ 14'h1FFF;
    return {{18{s[13]}}, s};
  endfunction

  function automatic sys_data_t loop_readback(dac_code_t c);
    return {{18{c[15]}}, c[15:2]};  // Top 14 bits of the code
  endfunction

  function automatic dac_word_t dac_converted(dac_code_t c);
    return c[15:2] ^ 14'h1FFF;      // Offset format, bit 15 kept
  endfunction

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic check_value(string name, sys_data_t exp_v, sys_data_t act_v);
    checks++;
    if (exp_v !== act_v)
    begin
      errors++;
      $display("FAIL t=%0t %s expected 0x%08h actual 0x%08h", $time, name, exp_v, act_v);
    end
  endtask

  task automatic add_access(logic wr, sys_addr_t addr, sys_data_t wdata, logic chk,
                            sys_data_t rdata, logic err);
    access_t e;
    e.wr    = wr;
    e.addr  = addr;
    e.wdata = wdata;
    e.chk   = chk;
    e.rdata = rdata;
    e.err   = err;
    table_q.push_back(e);
  endtask

  // One-cycle strobe, then wait for ack
  task automatic run_access(input access_t e, output sys_data_t rdata, output logic err);
    int   n;
    logic got;
    n     = 0;
    got   = 1'b0;
    rdata = '0;
    err   = 1'b0;
    @(posedge adc_clk);
    sys_req_i.addr  <= e.addr;
    sys_req_i.wdata <= e.wdata;
    sys_req_i.sel   <= 4'hF;
    sys_req_i.wen   <= e.wr;
    sys_req_i.ren   <= ~e.wr;
    @(negedge adc_clk);
    if (sys_rsp_o.ack)  // Empty regions answer in the strobe cycle
    begin
      got   = 1'b1;
      rdata = sys_rsp_o.rdata;
      err   = sys_rsp_o.err;
    end
    @(posedge adc_clk);
    sys_req_i.wen <= 1'b0;
    sys_req_i.ren <= 1'b0;
    while (!got && n < TIMEOUT)
    begin
      @(negedge adc_clk);
      if (sys_rsp_o.ack)
      begin
        got   = 1'b1;
        rdata = sys_rsp_o.rdata;
        err   = sys_rsp_o.err;
      end
      n++;
    end
    if (!got)
    begin
      errors++;
      $display("Timeout: no ack for access to address 0x%08h", e.addr);
    end
  endtask

  // Sel toggles each cycle and data follows sel
  task automatic check_dac_stream(dac_word_t word_a, dac_word_t word_b);
    logic prev_sel;
    @(negedge adc_clk);
    prev_sel = dac_sel_o;
    for (int k = 0; k < DAC_CYCLES; k++)
    begin
      @(negedge adc_clk);
      check_value("dac_sel_o", {31'd0, ~prev_sel}, {31'd0, dac_sel_o});
      check_value("dac_dat_o", {18'd0, dac_sel_o ? word_b : word_a}, {18'd0, dac_dat_o});
      prev_sel = dac_sel_o;
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial
  begin
    seed        = 32'heb36;
    errors      = 0;
    checks      = 0;
    reset_i     <= 1'b1;
    sys_req_i   <= '0;
    adc_dat_a_i <= '0;
    adc_dat_b_i <= '0;
    exp_p_dat_i <= '0;
    exp_n_dat_i <= '0;
    rnd         = $random(seed);
    pin_a       = rnd[15:0];
    pin_b       = rnd[31:16];
    rnd         = $random(seed);
    code_a      = rnd[15:0];
    code_b      = rnd[31:16];
    rnd         = $random(seed);
    exp_p_drv   = rnd[7:0];
    exp_n_drv   = rnd[15:8];

    @(posedge adc_clk);
    @(negedge adc_clk);
    check_value("dac_rst_o", 32'd1, {31'd0, dac_rst_o});  // Held in reset
    @(posedge adc_clk);
    reset_i     <= 1'b0;     // Two cycles of reset
    adc_dat_a_i <= pin_a;
    adc_dat_b_i <= pin_b;
    exp_p_dat_i <= exp_p_drv;
    exp_n_dat_i <= exp_n_drv;
    @(negedge adc_clk);
    check_value("dac_rst_o", 32'd1, {31'd0, dac_rst_o});  // Stretched one cycle
    check_value("dac_sel_o", 32'd0, {31'd0, dac_sel_o});
    check_value("dac_dat_o", 32'd0, {18'd0, dac_dat_o});
    check_value("sys_rsp_o.ack", 32'd0, {31'd0, sys_rsp_o.ack});
    check_value("sys_rsp_o.err", 32'd0, {31'd0, sys_rsp_o.err});
    check_value("led_o", 32'd0, {24'd0, led_o});
    check_value("exp_p_dir_o", 32'd0, {24'd0, exp_p_dir_o});
    check_value("exp_n_dir_o", 32'd0, {24'd0, exp_n_dir_o});
    check_value("exp_p_dat_o", 32'd0, {24'd0, exp_p_dat_o});
    check_value("exp_n_dat_o", 32'd0, {24'd0, exp_n_dat_o});
    @(negedge adc_clk);
    check_value("dac_rst_o", 32'd0, {31'd0, dac_rst_o});  // Released after one cycle

    // ID, empty regions, error cases
    add_access(1'b0, HK_OFS_ID, 32'd0, 1'b1, HK_ID, 1'b0);
    for (int r = 1; r < SYS_REGIONS; r++)
    begin
      add_access(1'b1, sys_addr_t'(r << REGION_LSB) | 32'h10, 32'hDEAD_0000 | r, 1'b1, 0, 1'b0);
      add_access(1'b0, sys_addr_t'(r << REGION_LSB) | 32'h10, 32'd0, 1'b1, 32'd0, 1'b0);
    end
    add_access(1'b0, 32'h34, 32'd0, 1'b0, 32'd0, 1'b1);          // Past the map
    add_access(1'b1, 32'h40, 32'h1, 1'b0, 32'd0, 1'b1);
    add_access(1'b1, HK_OFS_ID, 32'h1234, 1'b0, 32'd0, 1'b1);    // Read-only targets
    add_access(1'b1, HK_OFS_ADC_A, 32'h1, 1'b0, 32'd0, 1'b1);
    add_access(1'b1, HK_OFS_EXP_P_IN, 32'hFF, 1'b0, 32'd0, 1'b1);
    // Board I/O
    add_access(1'b1, HK_OFS_LED, {24'd0, LED_VAL}, 1'b0, 32'd0, 1'b0);
    add_access(1'b1, HK_OFS_EXP_P_DIR, {24'd0, P_DIR_VAL}, 1'b0, 32'd0, 1'b0);
    add_access(1'b1, HK_OFS_EXP_N_DIR, {24'd0, N_DIR_VAL}, 1'b0, 32'd0, 1'b0);
    add_access(1'b1, HK_OFS_EXP_P_OUT, {24'd0, P_OUT_VAL}, 1'b0, 32'd0, 1'b0);
    add_access(1'b1, HK_OFS_EXP_N_OUT, {24'd0, N_OUT_VAL}, 1'b0, 32'd0, 1'b0);
    add_access(1'b0, HK_OFS_LED, 32'd0, 1'b1, {24'd0, LED_VAL}, 1'b0);
    add_access(1'b0, HK_OFS_EXP_P_IN, 32'd0, 1'b1, {24'd0, exp_p_drv}, 1'b0);
    add_access(1'b0, HK_OFS_EXP_N_IN, 32'd0, 1'b1, {24'd0, exp_n_drv}, 1'b0);
    // ADC from the pins, then through the loop
    add_access(1'b0, HK_OFS_ADC_A, 32'd0, 1'b1, adc_readback(pin_a), 1'b0);
    add_access(1'b0, HK_OFS_ADC_B, 32'd0, 1'b1, adc_readback(pin_b), 1'b0);
    add_access(1'b1, HK_OFS_DAC_A, {16'd0, code_a}, 1'b0, 32'd0, 1'b0);
    add_access(1'b1, HK_OFS_DAC_B, {16'd0, code_b}, 1'b0, 32'd0, 1'b0);
    add_access(1'b1, HK_OFS_LOOP, 32'd1, 1'b0, 32'd0, 1'b0);
    add_access(1'b0, HK_OFS_LOOP, 32'd0, 1'b1, 32'd1, 1'b0);
    add_access(1'b0, HK_OFS_ADC_A, 32'd0, 1'b1, loop_readback(code_a), 1'b0);
    add_access(1'b0, HK_OFS_ADC_B, 32'd0, 1'b1, loop_readback(code_b), 1'b0);

    foreach (table_q[i])
    begin
      run_access(table_q[i], rd, er);
      if (table_q[i].chk)
        check_value($sformatf("sys_rsp_o.rdata (entry %0d)", i), table_q[i].rdata, rd);
      check_value($sformatf("sys_rsp_o.err (entry %0d)", i), {31'd0, table_q[i].err},
                  {31'd0, er});
    end

    check_value("led_o", {24'd0, LED_VAL}, {24'd0, led_o});
    check_value("exp_p_dir_o", {24'd0, P_DIR_VAL}, {24'd0, exp_p_dir_o});
    check_value("exp_n_dir_o", {24'd0, N_DIR_VAL}, {24'd0, exp_n_dir_o});
    check_value("exp_p_dat_o", {24'd0, P_OUT_VAL}, {24'd0, exp_p_dat_o});
    check_value("exp_n_dat_o", {24'd0, N_OUT_VAL}, {24'd0, exp_n_dat_o});

    // Codes long settled so both word registers are filled
    repeat (3) @(posedge adc_clk);
    check_dac_stream(dac_converted(code_a), dac_converted(code_b));

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

//--- rp_top.sv
`timescale 1ns/10ps

module rp_top
  import sys_bus_pkg::*;
  import analog_pkg::*;
(
  input  logic                 adc_clk,
  input  logic                 reset_i,
  // Processor register bus
  input  sys_req_t             sys_req_i,
  output sys_rsp_t             sys_rsp_o,
  // Converters
  input  logic [ADC_PIN_W-1:0] adc_dat_a_i,
  input  logic [ADC_PIN_W-1:0] adc_dat_b_i,
  output dac_word_t            dac_dat_o,
  output logic                 dac_sel_o,
  output logic                 dac_rst_o,
  // Board I/O
  output led_t                 led_o,
  input  exp_t                 exp_p_dat_i,
  input  exp_t                 exp_n_dat_i,
  output exp_t                 exp_p_dat_o,
  output exp_t                 exp_n_dat_o,
  output exp_t                 exp_p_dir_o,
  output exp_t                 exp_n_dir_o
);

  sys_req_t  hk_req;
  sys_rsp_t  hk_rsp;
  logic      digital_loop;
  dac_pair_t dac_codes;
  adc_pair_t adc_samples;

  //////////////////////////////////////////////////
  // Bus side
  //////////////////////////////////////////////////

  sys_bus_decoder i_sys_bus_decoder (
    .sys_req_i (sys_req_i),
    .sys_rsp_o (sys_rsp_o),
    .hk_req_o  (hk_req),
    .hk_rsp_i  (hk_rsp)
  );

  // Region 0
  housekeeping_regs i_housekeeping_regs (
    .adc_clk        (adc_clk),
    .reset_i        (reset_i),
    .hk_req_i       (hk_req),
    .hk_rsp_o       (hk_rsp),
    .led_o          (led_o),
    .exp_p_dat_i    (exp_p_dat_i),
    .exp_n_dat_i    (exp_n_dat_i),
    .exp_p_dat_o    (exp_p_dat_o),
    .exp_n_dat_o    (exp_n_dat_o),
    .exp_p_dir_o    (exp_p_dir_o),
    .exp_n_dir_o    (exp_n_dir_o),
    .digital_loop_o (digital_loop),
    .dac_codes_o    (dac_codes),
    .adc_samples_i  (adc_samples)
  );

  //////////////////////////////////////////////////
  // Converter side
  //////////////////////////////////////////////////

  adc_frontend i_adc_frontend (
    .adc_clk        (adc_clk),
    .adc_dat_a_i    (adc_dat_a_i),
    .adc_dat_b_i    (adc_dat_b_i),
    .digital_loop_i (digital_loop),  // Loop replaces pins with DAC codes
    .dac_codes_i    (dac_codes),
    .adc_samples_o  (adc_samples)
  );

  dac_backend i_dac_backend (
    .adc_clk     (adc_clk),
    .reset_i     (reset_i),
    .dac_codes_i (dac_codes),
    .dac_dat_o   (dac_dat_o),
    .dac_sel_o   (dac_sel_o),
    .dac_rst_o   (dac_rst_o)
  );

endmodule

//--- dac_backend.sv
`timescale 1ns/10ps

module dac_backend
  import analog_pkg::*;
(
  input  logic      adc_clk,
  input  logic      reset_i,
  input  dac_pair_t dac_codes_i,
  output dac_word_t dac_dat_o,   // Both channels interleaved
  output logic      dac_sel_o,   // Low for a, high for b
  output logic      dac_rst_o
);

  dac_word_t word_a_q, word_b_q;
  dac_word_t dat_q;
  logic      sel_q;
  logic      rst_q;  // Reset held one more cycle

  //////////////////////////////////////////////////
  // Offset conversion
  //////////////////////////////////////////////////

  // Keep bit 15, invert 14..2
  always_ff @(posedge adc_clk)
  begin
    word_a_q <= {dac_codes_i.a[DAC_CODE_W-1], ~dac_codes_i.a[DAC_CODE_W-2 -: DAC_W-1]};
    word_b_q <= {dac_codes_i.b[DAC_CODE_W-1], ~dac_codes_i.b[DAC_CODE_W-2 -: DAC_W-1]};
  end

  //////////////////////////////////////////////////
  // Interleave
  //////////////////////////////////////////////////

  // Data picked for the sel value it goes out with
  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      sel_q <= 1'b0;
      dat_q <= '0;
    end
    else
    begin
      sel_q <= ~sel_q;
      dat_q <= sel_q ? word_a_q : word_b_q;  // Next sel low means channel a
    end
  end

  always_ff @(posedge adc_clk)
  begin
    rst_q <= reset_i;
  end

  assign dac_dat_o = dat_q;
  assign dac_sel_o = sel_q;
  assign dac_rst_o = reset_i | rst_q;  // Stretched by one cycle

endmodule

//--- adc_frontend.sv
`timescale 1ns/10ps

module adc_frontend
  import analog_pkg::*;
(
  input  logic                 adc_clk,
  input  logic [ADC_PIN_W-1:0] adc_dat_a_i,    // Low 2 bits unused
  input  logic [ADC_PIN_W-1:0] adc_dat_b_i,
  input  logic                 digital_loop_i,
  input  dac_pair_t            dac_codes_i,
  output adc_pair_t            adc_samples_o
);

  adc_raw_t raw_a_q, raw_b_q;

  //////////////////////////////////////////////////
  // Input registers
  //////////////////////////////////////////////////

  // Top 14 bits of each pin word
  always_ff @(posedge adc_clk)
  begin
    raw_a_q <= adc_dat_a_i[ADC_PIN_W-1 -: ADC_W];
    raw_b_q <= adc_dat_b_i[ADC_PIN_W-1 -: ADC_W];
  end

  // Sign bit kept, rest inverted for negative slope
  // Loop takes the DAC codes straight through
  always_comb
  begin
    if (digital_loop_i)
    begin
      adc_samples_o.a = dac_codes_i.a[DAC_CODE_W-1 -: ADC_W];
      adc_samples_o.b = dac_codes_i.b[DAC_CODE_W-1 -: ADC_W];
    end
    else
    begin
      adc_samples_o.a = {raw_a_q[ADC_W-1], ~raw_a_q[ADC_W-2:0]};
      adc_samples_o.b = {raw_b_q[ADC_W-1], ~raw_b_q[ADC_W-2:0]};
    end
  end

endmodule

//--- housekeeping_regs.sv
`timescale 1ns/10ps

module housekeeping_regs
  import sys_bus_pkg::*;
  import analog_pkg::*;
(
  input  logic      adc_clk,
  input  logic      reset_i,
  input  sys_req_t  hk_req_i,       // Strobes already gated to region 0
  output sys_rsp_t  hk_rsp_o,
  output led_t      led_o,
  input  exp_t      exp_p_dat_i,
  input  exp_t      exp_n_dat_i,
  output exp_t      exp_p_dat_o,
  output exp_t      exp_n_dat_o,
  output exp_t      exp_p_dir_o,    // 1 means pin drives
  output exp_t      exp_n_dir_o,
  output logic      digital_loop_o,
  output dac_pair_t dac_codes_o,
  input  adc_pair_t adc_samples_i
);

  led_t      led_q;
  exp_t      exp_p_dir_q, exp_n_dir_q;
  exp_t      exp_p_out_q, exp_n_out_q;
  exp_t      exp_p_in_q, exp_n_in_q;  // Input capture
  logic      loop_q;
  dac_pair_t dac_q;
  adc_pair_t adc_q;                   // Sample readback
  sys_addr_t ofs;                     // Offset inside region
  sys_data_t rd_data;
  logic      mapped, read_only;
  logic      strobe;

  assign ofs    = {{(32-REGION_LSB){1'b0}}, hk_req_i.addr[REGION_LSB-1:0]};
  assign strobe = hk_req_i.wen | hk_req_i.ren;

  //////////////////////////////////////////////////
  // Read mux and map check
  //////////////////////////////////////////////////

  always_comb
  begin
    rd_data   = '0;
    mapped    = 1'b1;
    read_only = 1'b0;
    case (ofs)
      HK_OFS_ID:        begin rd_data = HK_ID; read_only = 1'b1; end
      HK_OFS_LOOP:      rd_data = {31'd0, loop_q};
      HK_OFS_EXP_P_DIR: rd_data = {24'd0, exp_p_dir_q};
      HK_OFS_EXP_N_DIR: rd_data = {24'd0, exp_n_dir_q};
      HK_OFS_EXP_P_OUT: rd_data = {24'd0, exp_p_out_q};
      HK_OFS_EXP_N_OUT: rd_data = {24'd0, exp_n_out_q};
      HK_OFS_EXP_P_IN:  begin rd_data = {24'd0, exp_p_in_q}; read_only = 1'b1; end
      HK_OFS_EXP_N_IN:  begin rd_data = {24'd0, exp_n_in_q}; read_only = 1'b1; end
      HK_OFS_LED:       rd_data = {24'd0, led_q};
      HK_OFS_DAC_A:     rd_data = {{(32-DAC_CODE_W){dac_q.a[DAC_CODE_W-1]}}, dac_q.a};
      HK_OFS_DAC_B:     rd_data = {{(32-DAC_CODE_W){dac_q.b[DAC_CODE_W-1]}}, dac_q.b};
      HK_OFS_ADC_A:     begin rd_data = {{(32-ADC_W){adc_q.a[ADC_W-1]}}, adc_q.a}; read_only = 1'b1; end
      HK_OFS_ADC_B:     begin rd_data = {{(32-ADC_W){adc_q.b[ADC_W-1]}}, adc_q.b}; read_only = 1'b1; end
      default:          mapped = 1'b0;  // Hole in the map
    endcase
  end

  //////////////////////////////////////////////////
  // Writable registers and response
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      led_q       <= '0;
      exp_p_dir_q <= '0;  // All pins input
      exp_n_dir_q <= '0;
      exp_p_out_q <= '0;
      exp_n_out_q <= '0;
      loop_q      <= 1'b0;
      dac_q       <= '0;
      hk_rsp_o.ack <= 1'b0;
      hk_rsp_o.err <= 1'b0;
    end
    else
    begin
      hk_rsp_o.ack <= strobe;  // One cycle after the strobe
      hk_rsp_o.err <= strobe & (~mapped | (hk_req_i.wen & read_only));
      if (hk_req_i.wen & mapped & ~read_only)
      begin
        case (ofs)
          HK_OFS_LOOP:      loop_q      <= hk_req_i.wdata[0];
          HK_OFS_EXP_P_DIR: exp_p_dir_q <= hk_req_i.wdata[$bits(exp_t)-1:0];
          HK_OFS_EXP_N_DIR: exp_n_dir_q <= hk_req_i.wdata[$bits(exp_t)-1:0];
          HK_OFS_EXP_P_OUT: exp_p_out_q <= hk_req_i.wdata[$bits(exp_t)-1:0];
          HK_OFS_EXP_N_OUT: exp_n_out_q <= hk_req_i.wdata[$bits(exp_t)-1:0];
          HK_OFS_LED:       led_q       <= hk_req_i.wdata[$bits(led_t)-1:0];
          HK_OFS_DAC_A:     dac_q.a     <= hk_req_i.wdata[DAC_CODE_W-1:0];
          HK_OFS_DAC_B:     dac_q.b     <= hk_req_i.wdata[DAC_CODE_W-1:0];
          default:          ;           // Read-only offsets filtered above
        endcase
      end
    end
  end

  // Capture every cycle, read data follows the decode
  always_ff @(posedge adc_clk)
  begin
    exp_p_in_q     <= exp_p_dat_i;
    exp_n_in_q     <= exp_n_dat_i;
    adc_q          <= adc_samples_i;  // One cycle behind the front end
    hk_rsp_o.rdata <= rd_data;
  end

  assign led_o          = led_q;
  assign exp_p_dat_o    = exp_p_out_q;
  assign exp_n_dat_o    = exp_n_out_q;
  assign exp_p_dir_o    = exp_p_dir_q;
  assign exp_n_dir_o    = exp_n_dir_q;
  assign digital_loop_o = loop_q;
  assign dac_codes_o    = dac_q;

endmodule

//--- sys_bus_decoder.sv
`timescale 1ns/10ps

module sys_bus_decoder
  import sys_bus_pkg::*;
(
  input  sys_req_t sys_req_i,  // From processor side
  output sys_rsp_t sys_rsp_o,
  output sys_req_t hk_req_o,   // Region 0 slot
  input  sys_rsp_t hk_rsp_i
);

  region_t                region;
  logic [SYS_REGIONS-1:0] sel_oh;     // One-hot region select
  logic                   strobe;
  sys_rsp_t               region_rsp [SYS_REGIONS];

  //////////////////////////////////////////////////
  // Region select
  //////////////////////////////////////////////////

  assign region = sys_req_i.addr[REGION_MSB:REGION_LSB];
  assign sel_oh = {{(SYS_REGIONS-1){1'b0}}, 1'b1} << region;
  assign strobe = sys_req_i.wen | sys_req_i.ren;

  // Housekeeping sees only its own strobes
  always_comb
  begin
    hk_req_o     = sys_req_i;
    hk_req_o.wen = sys_req_i.wen & sel_oh[0];
    hk_req_o.ren = sys_req_i.ren & sel_oh[0];
  end

  //////////////////////////////////////////////////
  // Response side
  //////////////////////////////////////////////////

  // Slot 0 is housekeeping, the rest are empty slaves
  always_comb
  begin
    region_rsp[0] = hk_rsp_i;
    for (int i = 1; i < SYS_REGIONS; i++)
    begin
      region_rsp[i].rdata = '0;
      region_rsp[i].err   = 1'b0;
      region_rsp[i].ack   = strobe;  // Answer in the strobe cycle
    end
  end

  // One-hot mux back to the master
  always_comb
  begin
    sys_rsp_o = '0;
    for (int i = 0; i < SYS_REGIONS; i++)
    begin
      if (sel_oh[i])
        sys_rsp_o = region_rsp[i];
    end
  end

endmodule

//--- analog_pkg.sv
package analog_pkg;

  //////////////////////////////////////////////////
  // Converter widths
  //////////////////////////////////////////////////

  localparam int ADC_PIN_W  = 16;  // Pin word, low 2 bits unused
  localparam int ADC_W      = 14;
  localparam int DAC_W      = 14;
  localparam int DAC_CODE_W = 16;  // Register code, top DAC_W bits used

  typedef logic        [ADC_W-1:0]      adc_raw_t;     // Straight from the pins
  typedef logic signed [ADC_W-1:0]      adc_sample_t;  // Two's complement
  typedef logic signed [DAC_CODE_W-1:0] dac_code_t;
  typedef logic        [DAC_W-1:0]      dac_word_t;    // Converter format

  typedef struct packed {
    dac_code_t a;
    dac_code_t b;
  } dac_pair_t;

  typedef struct packed {
    adc_sample_t a;
    adc_sample_t b;
  } adc_pair_t;

  // Read at the ID offset of the housekeeping block
  localparam logic [31:0] HK_ID = 32'h5250_0001;

endpackage

//--- sys_bus_pkg.sv
package sys_bus_pkg;

  //////////////////////////////////////////////////
  // System bus words
  //////////////////////////////////////////////////

  typedef logic [31:0] sys_addr_t;  // Byte address
  typedef logic [31:0] sys_data_t;
  typedef logic [3:0]  sys_sel_t;   // Byte select, one bit per lane

  // Request from the processor side, strobes last one cycle
  typedef struct packed {
    sys_addr_t addr;
    sys_data_t wdata;
    sys_sel_t  sel;
    logic      wen;   // Write strobe
    logic      ren;   // Read strobe
  } sys_req_t;

  // Slave answer
  typedef struct packed {
    sys_data_t rdata;
    logic      err;
    logic      ack;
  } sys_rsp_t;

  //////////////////////////////////////////////////
  // Region map
  //////////////////////////////////////////////////

  localparam int SYS_REGIONS = 8;
  localparam int REGION_LSB  = 20;  // 1 MB per region
  localparam int REGION_MSB  = 22;

  typedef logic [REGION_MSB-REGION_LSB:0] region_t;

  // Housekeeping register offsets inside region 0
  localparam sys_addr_t HK_OFS_ID        = 32'h00;
  localparam sys_addr_t HK_OFS_LOOP      = 32'h04;
  localparam sys_addr_t HK_OFS_EXP_P_DIR = 32'h08;
  localparam sys_addr_t HK_OFS_EXP_N_DIR = 32'h0C;
  localparam sys_addr_t HK_OFS_EXP_P_OUT = 32'h10;
  localparam sys_addr_t HK_OFS_EXP_N_OUT = 32'h14;
  localparam sys_addr_t HK_OFS_EXP_P_IN  = 32'h18;  // Read only
  localparam sys_addr_t HK_OFS_EXP_N_IN  = 32'h1C;  // Read only
  localparam sys_addr_t HK_OFS_LED       = 32'h20;
  localparam sys_addr_t HK_OFS_DAC_A     = 32'h24;
  localparam sys_addr_t HK_OFS_DAC_B     = 32'h28;
  localparam sys_addr_t HK_OFS_ADC_A     = 32'h2C;  // Read only
  localparam sys_addr_t HK_OFS_ADC_B     = 32'h30;  // Read only

  typedef logic [7:0] exp_t;  // Expansion connector, one bit per pin
  typedef logic [7:0] led_t;

endpackage
